//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -f filelist.f --top-module tb_exec_top \
		-Mdir obj_dir -o sim_exec
	./obj_dir/sim_exec | tee sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- filelist.f
hw/exec_pkg.sv
hw/exec_alu.sv
hw/exec_flags.sv
hw/exec_branch.sv
hw/exec_pipestage.sv
hw/exec_top.sv
verification/tb_exec_top.sv

//--- hw/exec_alu.sv
/*
 * Execute ALU.
 * Size-aware add, sub, logic, shift and pass with arithmetic flags
 * and a per-flag write mask.
 */
`timescale 1ns/1ps

module exec_alu
    import exec_pkg::*;
(
    input  word_t   a,
    input  word_t   b,
    input  alu_op_e alu_op,
    input  opsize_t opsize,
    output word_t   alu_out,
    output flags_t  flags_new,
    output flags_t  flags_we
);

    logic [4:0]    msb;
    logic [5:0]    cbit;
    word_t         mask;
    word_t         a_m;
    word_t         b_m;
    logic [4:0]    count;
    logic [XLEN:0] wide;
    word_t         res;
    logic          cf;
    logic          of;
    logic          wr;

    always_comb begin
        case (opsize)
            OPSIZE_8: begin
                msb  = 5'd7;
                mask = 32'h0000_00ff;
            end
            OPSIZE_16: begin
                msb  = 5'd15;
                mask = 32'h0000_ffff;
            end
            default: begin
                msb  = 5'd31;
                mask = 32'hffff_ffff;
            end
        endcase
    end

    // Carry out sits one above the sized msb
    assign cbit  = {1'b0, msb} + 6'd1;
    assign a_m   = a & mask;
    assign b_m   = b & mask;
    assign count = b[4:0];

    always_comb begin
        wide = '0;
        res  = '0;
        cf   = 1'b0;
        of   = 1'b0;
        wr   = 1'b1;
        case (alu_op)
            ALU_ADD: begin
                wide = {1'b0, a_m} + {1'b0, b_m};
                res  = wide[XLEN-1:0] & mask;
                cf   = wide[cbit];
                of   = (a_m[msb] == b_m[msb]) && (res[msb] != a_m[msb]);
            end
            ALU_SUB: begin
                wide = {1'b0, a_m} - {1'b0, b_m};
                res  = wide[XLEN-1:0] & mask;
                cf   = wide[cbit];
                of   = (a_m[msb] != b_m[msb]) && (res[msb] != a_m[msb]);
            end
            ALU_AND: res = a_m & b_m;
            ALU_OR:  res = a_m | b_m;
            ALU_XOR: res = a_m ^ b_m;
            ALU_SHL: begin
                wide = {1'b0, a_m} << count;
                res  = wide[XLEN-1:0] & mask;
                cf   = wide[cbit];
                wr   = (count != 5'd0);
            end
            ALU_SHR: begin
                // Extra low bit catches the last bit shifted out
                wide = {a_m, 1'b0} >> count;
                res  = wide[XLEN:1];
                cf   = wide[0];
                wr   = (count != 5'd0);
            end
            default: begin
                res = b_m;
                wr  = 1'b0;
            end
        endcase
    end

    always_comb begin
        alu_out            = res;
        flags_new          = '0;
        flags_new[FLAG_CF] = cf;
        flags_new[FLAG_ZF] = (res == '0);
        flags_new[FLAG_SF] = res[msb];
        flags_new[FLAG_OF] = of;
        flags_we           = '0;
        flags_we[FLAG_CF]  = wr;
        flags_we[FLAG_ZF]  = wr;
        flags_we[FLAG_SF]  = wr;
        flags_we[FLAG_OF]  = wr;
    end

endmodule

//--- hw/exec_branch.sv
/*
 * Conditional branch resolver.
 * Evaluates the condition on the current flags and forms the
 * redirect address and the misprediction bit.
 */
`timescale 1ns/1ps

module exec_branch
    import exec_pkg::*;
(
    input  cond_e     cond,
    input  logic      predicted_taken,
    input  flags_t    flags,
    input  word_t     pc,
    input  inst_len_t inst_len,
    input  word_t     disp,
    output logic      taken,
    output word_t     jump_address,
    output logic      misprediction
);

    word_t fall_through;

    always_comb begin
        case (cond)
            COND_NONE:   taken = 1'b0;
            COND_ALWAYS: taken = 1'b1;
            COND_Z:      taken = flags[FLAG_ZF];
            COND_NZ:     taken = !flags[FLAG_ZF];
            COND_C:      taken = flags[FLAG_CF];
            COND_NC:     taken = !flags[FLAG_CF];
            COND_S:      taken = flags[FLAG_SF];
            COND_NS:     taken = !flags[FLAG_SF];
            default:     taken = 1'b0;
        endcase
    end

    // Next sequential instruction
    assign fall_through = pc + word_t'(inst_len);

    always_comb begin
        if (taken) begin
            jump_address = fall_through + disp;
        end else begin
            jump_address = fall_through;
        end
    end

    assign misprediction = (taken != predicted_taken);

endmodule

//--- hw/exec_flags.sv
/*
 * Architectural flags register.
 * Masked update from the ALU plus direction flag set and clear.
 */
`timescale 1ns/1ps

module exec_flags
    import exec_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,
    input  logic   accept,
    input  flags_t flags_new,
    input  flags_t flags_we,
    input  logic   set_d_flag,
    input  logic   clear_d_flag,
    output flags_t flags_q,
    output flags_t flags_next
);

    flags_t flags_r;

    always_comb begin
        // Only written bits come from the ALU
        flags_next = (flags_r & ~flags_we) | (flags_new & flags_we);

        if (set_d_flag) begin
            flags_next[FLAG_DF] = 1'b1;
        end else if (clear_d_flag) begin
            flags_next[FLAG_DF] = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flags_r <= '0;
        end else if (accept) begin
            flags_r <= flags_next;
        end
    end

    assign flags_q = flags_r;

endmodule

//--- hw/exec_pipestage.sv
/*
 * Execute to writeback pipestage.
 * One-entry valid/ready register with a full bit and flush.
 */
`timescale 1ns/1ps

module exec_pipestage
    import exec_pkg::*;
(
    input  logic                clk,
    input  logic                arst_n,
    input  logic                flush,
    input  logic                in_valid,
    output logic                in_ready,
    input  logic [WB_WIDTH-1:0] in_data,
    output logic                accept,
    output logic                out_valid,
    input  logic                out_ready,
    output logic [WB_WIDTH-1:0] out_data
);

    logic                full_q;
    logic [WB_WIDTH-1:0] data_q;

    // Room when empty or draining this cycle
    assign in_ready  = !flush && (!full_q || out_ready);
    assign accept    = in_valid && in_ready;
    assign out_valid = full_q;
    assign out_data  = data_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            full_q <= 1'b0;
        end else if (flush) begin
            full_q <= 1'b0;
        end else if (accept) begin
            full_q <= 1'b1;
        end else if (out_ready) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            data_q <= in_data;
        end
    end

endmodule

//--- hw/exec_pkg.sv
/*
 * Execute stage shared definitions.
 * Data and flag widths, operand size codes, ALU and branch encodings.
 */
package exec_pkg;

    localparam int XLEN   = 32;
    localparam int FLAG_W = 5;

    // Flag bit positions
    localparam int FLAG_CF = 0;
    localparam int FLAG_ZF = 1;
    localparam int FLAG_SF = 2;
    localparam int FLAG_OF = 3;
    localparam int FLAG_DF = 4;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [FLAG_W-1:0] flags_t;
    typedef logic [2:0]        reg_idx_t;
    typedef logic [1:0]        opsize_t;
    typedef logic [3:0]        inst_len_t;

    // Operand size codes, 3 falls back to 32 bits
    localparam opsize_t OPSIZE_8  = 2'd0;
    localparam opsize_t OPSIZE_16 = 2'd1;
    localparam opsize_t OPSIZE_32 = 2'd2;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
        ALU_XOR, ALU_SHL, ALU_SHR, ALU_PASS
    } alu_op_e;

    typedef enum logic [2:0] {
        COND_NONE, COND_ALWAYS, COND_Z, COND_NZ,
        COND_C, COND_NC, COND_S, COND_NS
    } cond_e;

    // Writeback payload
    // result, dest reg, opsize, pc, flags, taken, jump address, mispredict
    localparam int WB_WIDTH = $bits(word_t) + $bits(reg_idx_t) + $bits(opsize_t)
                            + $bits(word_t) + $bits(flags_t) + 1
                            + $bits(word_t) + 1;

endpackage

//--- hw/exec_top.sv
/*
 * Execute stage top level.
 * ALU, flags register and branch resolver feeding the writeback pipestage.
 */
`timescale 1ns/1ps

module exec_top
    import exec_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      flush,

    // Decode side
    input  logic      e_valid,
    output logic      e_ready,
    input  word_t     e_op_a,
    input  word_t     e_op_b,
    input  alu_op_e   e_alu_op,
    input  opsize_t   e_opsize,
    input  reg_idx_t  e_dest_reg,
    input  cond_e     e_cond,
    input  logic      e_branch_taken,
    input  word_t     e_pc,
    input  inst_len_t e_inst_len,
    input  logic      e_set_d_flag,
    input  logic      e_clear_d_flag,

    // Writeback side
    input  logic      wb_ready,
    output logic      wb_valid,
    output word_t     wb_result,
    output reg_idx_t  wb_dest_reg,
    output opsize_t   wb_opsize,
    output word_t     wb_pc,
    output flags_t    wb_flags,
    output logic      wb_branch_taken,
    output word_t     wb_jump_address,
    output logic      wb_br_misprediction
);

    word_t               alu_out;
    flags_t              alu_flags;
    flags_t              alu_flags_we;
    flags_t              flags_q;
    flags_t              flags_next;
    logic                accept;
    logic                br_taken;
    word_t               br_address;
    logic                br_mispredict;
    logic [WB_WIDTH-1:0] pipe_in;
    logic [WB_WIDTH-1:0] pipe_out;

    exec_alu u_alu (
        .a         (e_op_a),
        .b         (e_op_b),
        .alu_op    (e_alu_op),
        .opsize    (e_opsize),
        .alu_out   (alu_out),
        .flags_new (alu_flags),
        .flags_we  (alu_flags_we)
    );

    exec_flags u_flags (
        .clk          (clk),
        .arst_n       (arst_n),
        .accept       (accept),
        .flags_new    (alu_flags),
        .flags_we     (alu_flags_we),
        .set_d_flag   (e_set_d_flag),
        .clear_d_flag (e_clear_d_flag),
        .flags_q      (flags_q),
        .flags_next   (flags_next)
    );

    // Displacement rides on operand b
    exec_branch u_branch (
        .cond            (e_cond),
        .predicted_taken (e_branch_taken),
        .flags           (flags_q),
        .pc              (e_pc),
        .inst_len        (e_inst_len),
        .disp            (e_op_b),
        .taken           (br_taken),
        .jump_address    (br_address),
        .misprediction   (br_mispredict)
    );

    assign pipe_in = {alu_out, e_dest_reg, e_opsize, e_pc, flags_next,
                      br_taken, br_address, br_mispredict};

    exec_pipestage u_stage (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .in_valid  (e_valid),
        .in_ready  (e_ready),
        .in_data   (pipe_in),
        .accept    (accept),
        .out_valid (wb_valid),
        .out_ready (wb_ready),
        .out_data  (pipe_out)
    );

    assign {wb_result, wb_dest_reg, wb_opsize, wb_pc, wb_flags,
            wb_branch_taken, wb_jump_address, wb_br_misprediction} = pipe_out;

endmodule

//--- verification/tb_exec_top.sv
/*
 * Testbench for the execute stage.
 * Random decode traffic, random writeback stalls and flushes,
 * checked against a reference model of the ALU, flags and branch rules.
 */
`timescale 1ns/1ps

module tb_exec_top
    import exec_pkg::*;
;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_OPS      = 2000;

    typedef struct packed {
        word_t    result;
        reg_idx_t dest_reg;
        opsize_t  opsize;
        word_t    pc;
        flags_t   flags;
        logic     taken;
        word_t    jump_address;
        logic     mispredict;
    } exp_item_t;

    logic      clk;
    logic      arst_n;
    logic      flush;
    logic      e_valid;
    logic      e_ready;
    word_t     e_op_a;
    word_t     e_op_b;
    alu_op_e   e_alu_op;
    opsize_t   e_opsize;
    reg_idx_t  e_dest_reg;
    cond_e     e_cond;
    logic      e_branch_taken;
    word_t     e_pc;
    inst_len_t e_inst_len;
    logic      e_set_d_flag;
    logic      e_clear_d_flag;
    logic      wb_ready;
    logic      wb_valid;
    word_t     wb_result;
    reg_idx_t  wb_dest_reg;
    opsize_t   wb_opsize;
    word_t     wb_pc;
    flags_t    wb_flags;
    logic      wb_branch_taken;
    word_t     wb_jump_address;
    logic      wb_br_misprediction;

    integer    seed;
    int        errors;
    int        checked;
    int        accepted;
    int        flushes;
    flags_t    model_flags;
    exp_item_t exp_q[$];

    exec_top u_dut (
        .clk                 (clk),
        .arst_n              (arst_n),
        .flush               (flush),
        .e_valid             (e_valid),
        .e_ready             (e_ready),
        .e_op_a              (e_op_a),
        .e_op_b              (e_op_b),
        .e_alu_op            (e_alu_op),
        .e_opsize            (e_opsize),
        .e_dest_reg          (e_dest_reg),
        .e_cond              (e_cond),
        .e_branch_taken      (e_branch_taken),
        .e_pc                (e_pc),
        .e_inst_len          (e_inst_len),
        .e_set_d_flag        (e_set_d_flag),
        .e_clear_d_flag      (e_clear_d_flag),
        .wb_ready            (wb_ready),
        .wb_valid            (wb_valid),
        .wb_result           (wb_result),
        .wb_dest_reg         (wb_dest_reg),
        .wb_opsize           (wb_opsize),
        .wb_pc               (wb_pc),
        .wb_flags            (wb_flags),
        .wb_branch_taken     (wb_branch_taken),
        .wb_jump_address     (wb_jump_address),
        .wb_br_misprediction (wb_br_misprediction)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Generous bound of 40 cycles per operation
    initial begin
        #(NUM_OPS * 40 * CLK_PERIOD);
        $display("timeout: only %0d of %0d outputs seen", checked, NUM_OPS);
        $display("TEST FAIL");
        $finish;
    end

    function automatic logic chance(input int percent);
        int rnd;
        rnd = $random(seed) & 32'h7fff_ffff;
        return (rnd % 100) < percent;
    endfunction

    // Two's complement value of the low w bits
    function automatic longint sized_signed(input word_t v, input int w);
        longint s;
        s = longint'({32'd0, v});
        if (v[w-1]) begin
            s = s - (longint'(1) << w);
        end
        return s;
    endfunction

    // Reference ALU on operands cut to the operand size
    function automatic void alu_ref(input word_t a, input word_t b, input alu_op_e op,
                                    input opsize_t size, output word_t res,
                                    output flags_t fl, output logic wr);
        int          w;
        int          cnt;
        word_t       mask;
        word_t       am;
        word_t       bm;
        logic [32:0] sum;
        longint      lim;
        longint      sd;
        logic        cf;
        logic        of;
        w    = (size == 2'd0) ? 8 : (size == 2'd1) ? 16 : 32;
        mask = (w == 32) ? 32'hffff_ffff : ((32'd1 << w) - 32'd1);
        am   = a & mask;
        bm   = b & mask;
        cnt  = int'(b[4:0]);
        lim  = longint'(1) << (w - 1);
        cf   = 1'b0;
        of   = 1'b0;
        wr   = 1'b1;
        case (op)
            ALU_ADD: begin
                sum = {1'b0, am} + {1'b0, bm};
                res = sum[31:0] & mask;
                cf  = sum[w];
                sd  = sized_signed(am, w) + sized_signed(bm, w);
                of  = (sd >= lim) || (sd < -lim);
            end
            ALU_SUB: begin
                res = (am - bm) & mask;
                cf  = (am < bm);
                sd  = sized_signed(am, w) - sized_signed(bm, w);
                of  = (sd >= lim) || (sd < -lim);
            end
            ALU_AND: res = am & bm;
            ALU_OR:  res = am | bm;
            ALU_XOR: res = am ^ bm;
            ALU_SHL: begin
                res = (am << cnt) & mask;
                cf  = (cnt >= 1 && cnt <= w) ? am[w-cnt] : 1'b0;
                wr  = (cnt != 0);
            end
            ALU_SHR: begin
                res = am >> cnt;
                cf  = (cnt >= 1) ? am[cnt-1] : 1'b0;
                wr  = (cnt != 0);
            end
            default: begin
                res = bm;
                wr  = 1'b0;
            end
        endcase
        fl          = '0;
        fl[FLAG_CF] = cf;
        fl[FLAG_ZF] = (res == 32'd0);
        fl[FLAG_SF] = res[w-1];
        fl[FLAG_OF] = of;
    endfunction

    task automatic drive_inputs();
        word_t r;
        r              = $random(seed);
        e_valid        = chance(70);
        wb_ready       = chance(60);
        flush          = chance(5);
        e_op_a         = $random(seed);
        // Equal operands now and then so SUB and XOR give zero
        e_op_b         = chance(25) ? e_op_a : $random(seed);
        e_alu_op       = alu_op_e'(r[2:0]);
        e_opsize       = opsize_t'(r[4:3]);
        e_dest_reg     = reg_idx_t'(r[7:5]);
        e_cond         = cond_e'(r[10:8]);
        e_branch_taken = r[11];
        e_inst_len     = inst_len_t'(r[15:12]);
        e_pc           = $random(seed);
        e_set_d_flag   = chance(10);
        e_clear_d_flag = chance(10);
    endtask

    task automatic compare_output(input exp_item_t e);
        if (wb_result !== e.result) begin
            errors++;
            $display("mismatch wb_result: got %h, expected %h", wb_result, e.result);
        end
        if (wb_dest_reg !== e.dest_reg) begin
            errors++;
            $display("mismatch wb_dest_reg: got %h, expected %h", wb_dest_reg, e.dest_reg);
        end
        if (wb_opsize !== e.opsize) begin
            errors++;
            $display("mismatch wb_opsize: got %h, expected %h", wb_opsize, e.opsize);
        end
        if (wb_pc !== e.pc) begin
            errors++;
            $display("mismatch wb_pc: got %h, expected %h", wb_pc, e.pc);
        end
        if (wb_flags !== e.flags) begin
            errors++;
            $display("mismatch wb_flags: got %h, expected %h", wb_flags, e.flags);
        end
        if (wb_branch_taken !== e.taken) begin
            errors++;
            $display("mismatch wb_branch_taken: got %h, expected %h",
                     wb_branch_taken, e.taken);
        end
        if (wb_jump_address !== e.jump_address) begin
            errors++;
            $display("mismatch wb_jump_address: got %h, expected %h",
                     wb_jump_address, e.jump_address);
        end
        if (wb_br_misprediction !== e.mispredict) begin
            errors++;
            $display("mismatch wb_br_misprediction: got %h, expected %h",
                     wb_br_misprediction, e.mispredict);
        end
    endtask

    // Predicts the next rising edge from the settled inputs
    task automatic step_model();
        exp_item_t item;
        word_t     res;
        flags_t    fl_new;
        flags_t    fl_next;
        logic      wr;
        logic      exp_ready;
        logic      exp_valid;
        exp_valid = (exp_q.size() != 0);
        exp_ready = !flush && (!exp_valid || wb_ready);
        if (e_ready !== exp_ready) begin
            errors++;
            $display("mismatch e_ready: got %h, expected %h", e_ready, exp_ready);
        end
        if (wb_valid !== exp_valid) begin
            errors++;
            $display("mismatch wb_valid: got %h, expected %h", wb_valid, exp_valid);
        end
        if (flush) begin
            exp_q.delete();
            flushes++;
        end else begin
            if (wb_valid && wb_ready && exp_valid) begin
                compare_output(exp_q.pop_front());
                checked++;
            end
            if (e_valid && exp_ready) begin
                alu_ref(e_op_a, e_op_b, e_alu_op, e_opsize, res, fl_new, wr);
                fl_next = wr ? {model_flags[FLAG_DF], fl_new[3:0]} : model_flags;
                if (e_set_d_flag) begin
                    fl_next[FLAG_DF] = 1'b1;
                end else if (e_clear_d_flag) begin
                    fl_next[FLAG_DF] = 1'b0;
                end
                case (e_cond)
                    COND_NONE:   item.taken = 1'b0;
                    COND_ALWAYS: item.taken = 1'b1;
                    COND_Z:      item.taken = model_flags[FLAG_ZF];
                    COND_NZ:     item.taken = !model_flags[FLAG_ZF];
                    COND_C:      item.taken = model_flags[FLAG_CF];
                    COND_NC:     item.taken = !model_flags[FLAG_CF];
                    COND_S:      item.taken = model_flags[FLAG_SF];
                    default:     item.taken = !model_flags[FLAG_SF];
                endcase
                item.result       = res;
                item.dest_reg     = e_dest_reg;
                item.opsize       = e_opsize;
                item.pc           = e_pc;
                item.flags        = fl_next;
                item.jump_address = e_pc + word_t'(e_inst_len)
                                  + (item.taken ? e_op_b : 32'd0);
                item.mispredict   = (item.taken != e_branch_taken);
                exp_q.push_back(item);
                model_flags = fl_next;
                accepted++;
            end
        end
    endtask

    initial begin
        seed           = 32'h7ab3;
        errors         = 0;
        checked        = 0;
        accepted       = 0;
        flushes        = 0;
        model_flags    = '0;
        arst_n         = 1'b0;
        flush          = 1'b0;
        e_valid        = 1'b0;
        e_op_a         = '0;
        e_op_b         = '0;
        e_alu_op       = ALU_ADD;
        e_opsize       = OPSIZE_32;
        e_dest_reg     = '0;
        e_cond         = COND_NONE;
        e_branch_taken = 1'b0;
        e_pc           = '0;
        e_inst_len     = '0;
        e_set_d_flag   = 1'b0;
        e_clear_d_flag = 1'b0;
        wb_ready       = 1'b0;

        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;
        #1;
        if (wb_valid !== 1'b0) begin
            errors++;
            $display("mismatch wb_valid after reset: got %h, expected 0", wb_valid);
        end

        while (checked < NUM_OPS) begin
            @(negedge clk);
            drive_inputs();
            #1;
            step_model();
        end

        $display("checked %0d outputs, accepted %0d, flushes %0d, errors %0d",
                 checked, accepted, flushes, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
